// ==== conv_layer.f ====
verilog/conv_pkg.sv
verilog/conv_window_seq.sv
verilog/conv_tap_mem.sv
verilog/conv_mac_array.sv
verilog/conv_requant.sv
verilog/conv_layer_top.sv
bench/conv_layer_tb.sv

// ==== Makefile ====
# Verilator build and run of the conv layer testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = conv_layer_tb
FILELIST = conv_layer.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Verification failed
PASS_MSG = Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), scan $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bench/conv_layer_stim.txt ====
// per run: 162 feature words (ch, row, col), 72 kernel words (lane, tap), 4 biases (lane),
// then 16 expected ofm vectors (position), each as lane 0..3
// run 1
0000 0001 0002 0003 0004 0005 0006 0007 0008 0009 000a 000b 000c 000d 000e 000f 0010 0011
0012 0013 0014 0015 0016 0017 0018 0019 001a 001b 001c 001d 001e 001f 0020 0021 0022 0023
0024 0025 0026 0027 0028 0029 002a 002b 002c 002d 002e 002f 0030 0031 0032 0033 0034 0035
0036 0037 0038 0039 003a 003b 003c 003d 003e 003f 0040 0041 0042 0043 0044 0045 0046 0047
0048 0049 004a 004b 004c 004d 004e 004f 0050 0000 0001 0002 0003 0004 0005 0006 0007 0008
ffff 0000 0001 0002 0003 0004 0005 0006 0007 fffe ffff 0000 0001 0002 0003 0004 0005 0006
fffd fffe ffff 0000 0001 0002 0003 0004 0005 fffc fffd fffe ffff 0000 0001 0002 0003 0004
fffb fffc fffd fffe ffff 0000 0001 0002 0003 fffa fffb fffc fffd fffe ffff 0000 0001 0002
fff9 fffa fffb fffc fffd fffe ffff 0000 0001 fff8 fff9 fffa fffb fffc fffd fffe ffff 0000
0000 0000 0000 0000 4000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 4000 0000 4000 0000 0000 0000 0000 0000 4000
0000 c000 0000 0000 0000 0000 0000 0000 4000 0000 c000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 c000 0000 4000 0000 0000 0000 0000 0000 0000 c000 0000 c000 0000 0000 0000
00002000 0000c000 fffec000 00004000
000a 0005 000d 0003 000c 000b 000b 0000 000e 0011 0009 0000 0010 0017 0007 0000
001c 0000 000f 0007 001e 0005 000d 0003 0020 000b 000b 0000 0022 0011 0009 0000
002e 0000 0011 000b 0030 0000 000f 0007 0032 0005 000d 0003 0034 000b 000b 0000
0040 0000 0013 000f 0042 0000 0011 000b 0044 0000 000f 0007 0046 0005 000d 0003
// run 2
0000 0040 0080 00c0 0100 0140 0180 01c0 0200 0240 0280 02c0 0300 0340 0380 03c0 0400 0440
0480 04c0 0500 0540 0580 05c0 0600 0640 0680 06c0 0700 0740 0780 07c0 0800 0840 0880 08c0
0900 0940 0980 09c0 0a00 0a40 0a80 0ac0 0b00 0b40 0b80 0bc0 0c00 0c40 0c80 0cc0 0d00 0d40
0d80 0dc0 0e00 0e40 0e80 0ec0 0f00 0f40 0f80 0fc0 1000 1040 1080 10c0 1100 1140 1180 11c0
1200 1240 1280 12c0 1300 1340 1380 13c0 1400 0000 0040 0080 00c0 0100 0140 0180 01c0 0200
ffc0 0000 0040 0080 00c0 0100 0140 0180 01c0 ff80 ffc0 0000 0040 0080 00c0 0100 0140 0180
ff40 ff80 ffc0 0000 0040 0080 00c0 0100 0140 ff00 ff40 ff80 ffc0 0000 0040 0080 00c0 0100
fec0 ff00 ff40 ff80 ffc0 0000 0040 0080 00c0 fe80 fec0 ff00 ff40 ff80 ffc0 0000 0040 0080
fe40 fe80 fec0 ff00 ff40 ff80 ffc0 0000 0040 fe00 fe40 fe80 fec0 ff00 ff40 ff80 ffc0 0000
0000 0000 0000 0000 2000 0000 0000 0000 0000 0000 0000 0000 0000 4000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 4000 0000 4000 0000 0000 0000 0000 0000 4000
0000 c000 0000 0000 0000 0000 0000 0000 4000 0000 c000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 c000 0000 4000 0000 0000 0000 0000 0000 0000 c000 0000 c000 0000 0000 0000
00000000 ffb50000 00400000 ff830000
0140 0000 0580 0000 0200 00d4 0500 0000 02c0 0254 0480 0000 0380 03d4 0400 0000
0300 0000 0600 0000 03c0 0000 0580 0000 0480 00d4 0500 0000 0540 0254 0480 0000
04c0 0000 0680 008c 0580 0000 0600 0000 0640 0000 0580 0000 0700 00d4 0500 0000
0680 0000 0700 018c 0740 0000 0680 008c 0800 0000 0600 0000 08c0 0000 0580 0000

// ==== bench/conv_layer_tb.sv ====
/* conv layer testbench: stim file loader, output value and strobe
   timing checks, finish level checks, watchdog */
module conv_layer_tb;
	import conv_pkg::*;

	localparam int RUNS      = 2;
	localparam int KER_WORDS = CH_OUT * TAPS;
	localparam int EXP_OFS   = IFM_DEPTH + KER_WORDS + CH_OUT;   // expected vectors inside a run
	localparam int RUN_WORDS = EXP_OFS + OUT_PIX * CH_OUT;       // 302 words per run
	localparam int FIRST_LAT = 21;                               // start to first strobe
	localparam int STRAY_AT  = 100;                              // stray start, mid run 2
	localparam int LOAD_CYC  = EXP_OFS + 3;
	localparam int RUN_CYC   = FIRST_LAT + OUT_PIX * TAPS + 2 * TAPS;
	localparam int LIMIT_T   = 2 * 10 * (20 + 2 * TAPS + RUNS * (LOAD_CYC + RUN_CYC));

	logic        clk;
	logic        rst_n;
	logic        ifm_we;
	ifm_addr_t   ifm_waddr;
	pix_t        ifm_wdata;
	logic        ker_we;
	logic [1:0]  ker_lane;
	tap_t        ker_waddr;
	pix_t        ker_wdata;
	logic        bias_we;
	logic [1:0]  bias_lane;
	acc_t        bias_wdata;
	logic        start;
	ofm_vec_t    ofm;
	logic        ofm_valid;
	logic        finish;

	logic [31:0] stim [RUNS * RUN_WORDS];   // both runs back to back
	int          checks;
	int          errors;
	int          tests;
	int          tests_failed;

	conv_layer_top uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.ifm_we     (ifm_we),
		.ifm_waddr  (ifm_waddr),
		.ifm_wdata  (ifm_wdata),
		.ker_we     (ker_we),
		.ker_lane   (ker_lane),
		.ker_waddr  (ker_waddr),
		.ker_wdata  (ker_wdata),
		.bias_we    (bias_we),
		.bias_lane  (bias_lane),
		.bias_wdata (bias_wdata),
		.start      (start),
		.ofm        (ofm),
		.ofm_valid  (ofm_valid),
		.finish     (finish)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// watchdog, two runs plus loads with 2x margin
	initial begin
		#(LIMIT_T);
		$display("timeout: layer runs did not complete within %0d time units", LIMIT_T);
		$display("Verification failed");
		$finish;
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			$display("ERR %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: FAIL with %0d errors", name, errors - err_before);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// host load, one write per cycle
	//////////////////////////////////////////////////////////////////////
	task automatic load_run(input int run);
		int base;
		int i;
		base = run * RUN_WORDS;
		for (i = 0; i < IFM_DEPTH; i++) begin
			@(negedge clk);
			ifm_we    = 1'b1;
			ifm_waddr = ifm_addr_t'(i);   // ch*81 + row*9 + col
			ifm_wdata = pix_t'(stim[base + i]);
		end
		for (i = 0; i < KER_WORDS; i++) begin
			@(negedge clk);
			ifm_we    = 1'b0;
			ker_we    = 1'b1;
			ker_lane  = 2'(i / TAPS);   // lane major
			ker_waddr = tap_t'(i % TAPS);
			ker_wdata = pix_t'(stim[base + IFM_DEPTH + i]);
		end
		for (i = 0; i < CH_OUT; i++) begin
			@(negedge clk);
			ker_we     = 1'b0;
			bias_we    = 1'b1;
			bias_lane  = 2'(i);
			bias_wdata = acc_t'(stim[base + IFM_DEPTH + KER_WORDS + i]);
		end
		@(negedge clk);
		bias_we = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// one layer run: values, strobe spacing, finish level
	//////////////////////////////////////////////////////////////////////
	task automatic run_layer(input int run, input bit stray);
		int exp_base;
		int cyc;
		int strobes;
		int extra;
		int l;
		exp_base = run * RUN_WORDS + EXP_OFS;
		cyc      = 0;
		strobes  = 0;
		extra    = 0;
		load_run(run);
		if (run > 0)
			check_val("finish before start", 32'(1), 32'(finish));   // held across reload
		@(negedge clk);
		start = 1'b1;
		while (strobes < OUT_PIX) begin
			@(negedge clk);
			cyc++;
			start = stray && (cyc == STRAY_AT);   // one cycle pulse while busy
			if (ofm_valid) begin
				check_val($sformatf("ofm_valid cycle of strobe %0d", strobes),
					32'(FIRST_LAT + strobes * TAPS), 32'(cyc));
				for (l = 0; l < CH_OUT; l++)
					check_val($sformatf("ofm.w[%0d] pos %0d", l, strobes),
						stim[exp_base + strobes * CH_OUT + l], 32'(ofm.w[l]));
				strobes++;
			end
			check_val("finish", 32'(strobes == OUT_PIX), 32'(finish));   // rises on 16th
		end
		start = 1'b0;
		repeat (2 * TAPS) begin
			@(negedge clk);
			if (ofm_valid)
				extra++;
			check_val("finish", 32'(1), 32'(finish));
		end
		check_val("ofm_valid count", 32'(OUT_PIX), 32'(OUT_PIX + extra));
	endtask

	initial begin
		int err_mark;
		rst_n      = 1'b0;
		start      = 1'b0;
		ifm_we     = 1'b0;
		ifm_waddr  = '0;
		ifm_wdata  = '0;
		ker_we     = 1'b0;
		ker_lane   = '0;
		ker_waddr  = '0;
		ker_wdata  = '0;
		bias_we    = 1'b0;
		bias_lane  = '0;
		bias_wdata = '0;
		checks       = 0;
		errors       = 0;
		tests        = 0;
		tests_failed = 0;
		$readmemh("bench/conv_layer_stim.txt", stim);
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		// quiet outputs before any start
		err_mark = errors;
		if ($isunknown(stim[RUNS * RUN_WORDS - 1])) begin
			$display("stim file bench/conv_layer_stim.txt is missing or too short");
			errors++;
		end
		repeat (2 * TAPS) begin
			@(negedge clk);
			check_val("ofm_valid", 32'(0), 32'(ofm_valid));
			check_val("finish", 32'(0), 32'(finish));
		end
		report_test("reset_idle", err_mark);

		err_mark = errors;
		run_layer(0, 1'b0);   // mixed sign data
		report_test("run1_mixed_sign", err_mark);

		err_mark = errors;
		run_layer(1, 1'b1);   // negative biases, relu, stray start
		report_test("run2_bias_relu", err_mark);

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests, tests_failed, checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== verilog/conv_layer_top.sv ====
/* conv layer top: sequencer, tap memories, mac array, requantizer */
module conv_layer_top (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 ifm_we,
	input  conv_pkg::ifm_addr_t                  ifm_waddr,
	input  conv_pkg::pix_t                       ifm_wdata,
	input  logic                                 ker_we,
	input  logic [$clog2(conv_pkg::CH_OUT)-1:0]  ker_lane,
	input  conv_pkg::tap_t                       ker_waddr,
	input  conv_pkg::pix_t                       ker_wdata,
	input  logic                                 bias_we,
	input  logic [$clog2(conv_pkg::CH_OUT)-1:0]  bias_lane,
	input  conv_pkg::acc_t                       bias_wdata,
	input  logic                                 start,
	output conv_pkg::ofm_vec_t                   ofm,
	output logic                                 ofm_valid,
	output logic                                 finish
);
	import conv_pkg::*;

	tap_req_t                req;
	logic                    req_valid;
	pix_t                    pix;
	lane_words_t             ker;
	logic                    d_first;
	logic                    d_last;
	logic                    d_valid;
	acc_t [CH_OUT-1:0]       acc_vec;
	logic                    acc_valid;
	acc_t [CH_OUT-1:0]       bias_vec;

	// decode
	conv_window_seq u_seq (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.req       (req),
		.req_valid (req_valid),
		.busy      ()   // gating is internal to the sequencer
	);

	conv_tap_mem u_mem (
		.clk        (clk),
		.rst_n      (rst_n),
		.ifm_we     (ifm_we),
		.ifm_waddr  (ifm_waddr),
		.ifm_wdata  (ifm_wdata),
		.ker_we     (ker_we),
		.ker_lane   (ker_lane),
		.ker_waddr  (ker_waddr),
		.ker_wdata  (ker_wdata),
		.bias_we    (bias_we),
		.bias_lane  (bias_lane),
		.bias_wdata (bias_wdata),
		.req        (req),
		.req_valid  (req_valid),
		.pix        (pix),
		.ker        (ker),
		.d_first    (d_first),
		.d_last     (d_last),
		.d_valid    (d_valid),
		.bias_vec   (bias_vec)
	);

	// execute
	conv_mac_array u_mac (
		.clk       (clk),
		.rst_n     (rst_n),
		.pix       (pix),
		.ker       (ker),
		.d_first   (d_first),
		.d_last    (d_last),
		.d_valid   (d_valid),
		.acc_vec   (acc_vec),
		.acc_valid (acc_valid)
	);

	// result
	conv_requant u_rq (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (start),
		.acc_vec   (acc_vec),
		.acc_valid (acc_valid),
		.bias_vec  (bias_vec),
		.ofm       (ofm),
		.ofm_valid (ofm_valid),
		.finish    (finish)
	);

endmodule

// ==== verilog/conv_requant.sv ====
/* requantizer: bias add, relu, q1.14 bit select,
   output strobe and layer finish level */
module conv_requant (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   start,
	input  conv_pkg::acc_t [conv_pkg::CH_OUT-1:0]  acc_vec,
	input  logic                                   acc_valid,
	input  conv_pkg::acc_t [conv_pkg::CH_OUT-1:0]  bias_vec,
	output conv_pkg::ofm_vec_t                     ofm,
	output logic                                   ofm_valid,
	output logic                                   finish
);
	import conv_pkg::*;

	localparam int MSB = FRAC + $bits(ofm_t) - 2;   // bit 28

	acc_t sum [CH_OUT];
	pos_t out_cnt;

	always_comb begin
		for (int l = 0; l < CH_OUT; l++)
			sum[l] = acc_vec[l] + bias_vec[l];   // wraps on overflow
	end

	always_ff @(posedge clk) begin
		if (acc_valid) begin
			for (int l = 0; l < CH_OUT; l++)
				ofm.w[l] <= sum[l][31] ? '0 : {1'b0, sum[l][MSB:FRAC]};   // relu
		end
	end

	//////////////////////////////////////////////////////////////////////
	// output count and finish
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ofm_valid <= 1'b0;
			finish    <= 1'b0;
			out_cnt   <= '0;
		end else begin
			ofm_valid <= acc_valid;
			if (start)
				finish <= 1'b0;
			if (acc_valid) begin
				out_cnt <= out_cnt + 1'b1;   // wraps after the 16th
				if (out_cnt == pos_t'(OUT_PIX - 1))
					finish <= 1'b1;   // same edge as the last strobe
			end
		end
	end

endmodule

// ==== verilog/conv_mac_array.sv ====
/* mac array: one multiply-accumulate lane per output channel */
module conv_mac_array (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  conv_pkg::pix_t                         pix,
	input  conv_pkg::lane_words_t                  ker,
	input  logic                                   d_first,
	input  logic                                   d_last,
	input  logic                                   d_valid,
	output conv_pkg::acc_t [conv_pkg::CH_OUT-1:0]  acc_vec,
	output logic                                   acc_valid
);
	import conv_pkg::*;

	acc_t prod [CH_OUT];
	logic win_open;   // between a first and its last

	always_comb begin
		for (int l = 0; l < CH_OUT; l++)
			prod[l] = pix * ker.w[l];   // signed 16x16 into 32
	end

	// accumulators reload on the first tap of each window
	always_ff @(posedge clk) begin
		if (d_valid) begin
			for (int l = 0; l < CH_OUT; l++)
				acc_vec[l] <= d_first ? prod[l] : acc_vec[l] + prod[l];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc_valid <= 1'b0;
			win_open  <= 1'b0;
		end else begin
			acc_valid <= d_valid && d_last;   // sum complete next cycle
			if (d_valid && d_first)
				win_open <= !d_last;
			else if (d_valid && d_last)
				win_open <= 1'b0;
		end
	end

	a_first_after_last: assert property (@(posedge clk) disable iff (!rst_n)
		d_valid && d_first |-> !win_open)
		else $error("window restarted before its last tap");

endmodule

// ==== verilog/conv_tap_mem.sv ====
/* feature memory, kernel memory and bias bank with host writes;
   tap reads registered one cycle after the request */
module conv_tap_mem (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   ifm_we,
	input  conv_pkg::ifm_addr_t                    ifm_waddr,
	input  conv_pkg::pix_t                         ifm_wdata,
	input  logic                                   ker_we,
	input  logic [$clog2(conv_pkg::CH_OUT)-1:0]    ker_lane,
	input  conv_pkg::tap_t                         ker_waddr,
	input  conv_pkg::pix_t                         ker_wdata,
	input  logic                                   bias_we,
	input  logic [$clog2(conv_pkg::CH_OUT)-1:0]    bias_lane,
	input  conv_pkg::acc_t                         bias_wdata,
	input  conv_pkg::tap_req_t                     req,
	input  logic                                   req_valid,
	output conv_pkg::pix_t                         pix,
	output conv_pkg::lane_words_t                  ker,
	output logic                                   d_first,
	output logic                                   d_last,
	output logic                                   d_valid,
	output conv_pkg::acc_t [conv_pkg::CH_OUT-1:0]  bias_vec
);
	import conv_pkg::*;

	pix_t ifm_mem [IFM_DEPTH];
	pix_t ker_mem [CH_OUT][TAPS];   // lane, tap

	// host side
	always_ff @(posedge clk) begin
		if (ifm_we)
			ifm_mem[ifm_waddr] <= ifm_wdata;
		if (ker_we)
			ker_mem[ker_lane][ker_waddr] <= ker_wdata;
		if (bias_we)
			bias_vec[bias_lane] <= bias_wdata;   // bias held until reloaded
	end

	// tap read, all lanes share the tap index
	always_ff @(posedge clk) begin
		if (req_valid) begin
			pix <= ifm_mem[req.ifm_addr];
			for (int l = 0; l < CH_OUT; l++)
				ker.w[l] <= ker_mem[l][req.tap];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			d_valid <= 1'b0;
			d_first <= 1'b0;
			d_last  <= 1'b0;
		end else begin
			d_valid <= req_valid;
			d_first <= req_valid && req.first;
			d_last  <= req_valid && req.last;
		end
	end

	a_no_load_in_run: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid |-> !(ifm_we || ker_we || bias_we))
		else $error("host write during a run");

endmodule

// ==== verilog/conv_window_seq.sv ====
/* window sequencer: walks the output positions and their taps,
   one tap request per cycle */
module conv_window_seq (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	output conv_pkg::tap_req_t req,
	output logic               req_valid,
	output logic               busy
);
	import conv_pkg::*;

	seq_state_t state;
	ifm_addr_t  ref_addr;   // top left pixel of current window, channel 0
	tap_t       tap_cnt;
	pos_t       pos;        // [3:2] out row, [1:0] out col
	logic       issue;
	logic       win_last;
	logic       run_last;

	// channel, row and column offset of a tap inside the window
	function automatic ifm_addr_t tap_offset(input tap_t t);
		int ch;
		int r;
		int c;
		ch = int'(t) / (K_DIM * K_DIM);
		r  = (int'(t) % (K_DIM * K_DIM)) / K_DIM;
		c  = int'(t) % K_DIM;
		return ifm_addr_t'(ch * W_IN * W_IN + r * W_IN + c);
	endfunction

	assign issue    = (state == RUN) || (state == IDLE && start); // start edge issues tap 0
	assign win_last = (tap_cnt == tap_t'(TAPS - 1));
	assign run_last = win_last && (pos == pos_t'(OUT_PIX - 1));
	assign busy     = (state != IDLE);   // start ignored while set

	//////////////////////////////////////////////////////////////////////
	// state and counters
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= IDLE;
			req_valid <= 1'b0;
			tap_cnt   <= '0;
			pos       <= '0;
			ref_addr  <= '0;
		end else begin
			req_valid <= issue;
			case (state)
				IDLE:    if (start) state <= RUN;
				RUN:     if (run_last) state <= DONE;
				default: state <= IDLE;   // done lasts one cycle
			endcase
			if (issue) begin
				if (win_last) begin
					tap_cnt <= '0;
					pos     <= pos + 1'b1;   // wraps to 0 after the 16th window
					if (run_last)
						ref_addr <= '0;
					else if (pos[1:0] == 2'(W_OUT - 1))   // row end, back to col 0 two rows down
						ref_addr <= ref_addr + ifm_addr_t'(STRIDE * W_IN - (W_OUT - 1) * STRIDE);
					else
						ref_addr <= ref_addr + ifm_addr_t'(STRIDE);
				end else begin
					tap_cnt <= tap_cnt + 1'b1;
				end
			end
		end
	end

	// request payload
	always_ff @(posedge clk) begin
		if (issue) begin
			req.ifm_addr <= ref_addr + tap_offset(tap_cnt);
			req.tap      <= tap_cnt;
			req.first    <= (tap_cnt == '0);
			req.last     <= win_last;
		end
	end

	a_tap_range: assert property (@(posedge clk) disable iff (!rst_n)
		tap_cnt <= tap_t'(TAPS - 1))
		else $error("tap counter out of range");

	a_first_last: assert property (@(posedge clk) disable iff (!rst_n)
		req_valid |-> !(req.first && req.last))
		else $error("first and last on one tap");

endmodule

// ==== verilog/conv_pkg.sv ====
/* conv layer package: geometry constants, word typedefs,
   tap request and lane structs, sequencer state */
package conv_pkg;

	//////////////////////////////////////////////////////////////////////
	// layer geometry
	//////////////////////////////////////////////////////////////////////
	localparam int W_IN      = 9;                    // padded input side
	localparam int CH_IN     = 2;
	localparam int CH_OUT    = 4;                    // one mac lane each
	localparam int K_DIM     = 3;
	localparam int STRIDE    = 2;
	localparam int W_OUT     = 4;
	localparam int TAPS      = K_DIM * K_DIM * CH_IN;   // 18 taps per window
	localparam int IFM_DEPTH = W_IN * W_IN * CH_IN;     // 162 words
	localparam int FRAC      = 14;                   // q1.14 fixed point
	localparam int OUT_PIX   = W_OUT * W_OUT;

	// word types
	typedef logic signed [15:0] pix_t;   // feature or weight
	typedef logic signed [31:0] acc_t;   // product sum, bias
	typedef logic [15:0]        ofm_t;   // relu output, never negative
	typedef logic [7:0]         ifm_addr_t;
	typedef logic [4:0]         tap_t;
	typedef logic [3:0]         pos_t;   // {row, col} of output pixel

	// one window tap, sequencer to memories
	typedef struct packed {
		ifm_addr_t ifm_addr;
		tap_t      tap;     // kernel word index
		logic      first;   // restarts the accumulators
		logic      last;    // closes the window
	} tap_req_t;

	typedef struct packed {
		pix_t [CH_OUT-1:0] w;   // kernel word per lane
	} lane_words_t;

	typedef struct packed {
		ofm_t [CH_OUT-1:0] w;
	} ofm_vec_t;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DONE
	} seq_state_t;

endpackage
